//--- src/rf_defines.svh
/*
 * Register file dimensions
 * Data width, address width and word count of the integer register file
 */

`ifndef RF_DEFINES_SVH
`define RF_DEFINES_SVH

// Width of one register
`define RF_DATA_WIDTH 32

// Width of a register index
`define RF_ADDR_WIDTH 5

// Words including the hardwired x0
`define RF_NUM_WORDS 32

`endif

//--- src/rf_pkg.sv
/*
 * Register file package
 * Index and value types plus the write, read request and operand structs
 */

`default_nettype none

`include "rf_defines.svh"

package rf_pkg;

  // Register index
  typedef logic [`RF_ADDR_WIDTH-1:0] reg_addr_t;

  // Register value
  typedef logic [`RF_DATA_WIDTH-1:0] reg_data_t;

  // Write command from writeback
  typedef struct packed {
    reg_addr_t addr;
    reg_data_t data;
  } rf_write_t;

  // Two source register indices
  typedef struct packed {
    reg_addr_t addr_a;
    reg_addr_t addr_b;
  } rf_read_req_t;

  // Operand pair returned to the core
  typedef struct packed {
    reg_data_t op_a;
    reg_data_t op_b;
  } rf_operands_t;

endpackage

`default_nettype wire

//--- src/rf_clock_gate.sv
/*
 * Integrated clock gating cell
 * Behavioral ICG with a low-transparent enable latch and a scan test enable
 */

`timescale 1ns/1ps
`default_nettype none

module rf_clock_gate (
  input  logic clk_i,
  input  logic en_i,
  input  logic test_en_i,
  output logic clk_o
);

  logic en_q;

  // Enable latch, open while the clock is low
  // Holds steady through the high phase so the output cannot glitch
  always_latch begin
    if (!clk_i) begin
      en_q <= en_i | test_en_i;
    end
  end

  // Gated clock
  assign clk_o = clk_i & en_q;

endmodule

`default_nettype wire

//--- src/rf_latch_file.sv
/*
 * Latch-based integer register file
 * 31 latch words behind a global and a per-word clock gate
 * One write port and two combinational read ports, x0 reads as zero
 */

`timescale 1ns/1ps
`default_nettype none

`include "rf_defines.svh"

module rf_latch_file import rf_pkg::*; (
  input  logic      clk_int,
  input  logic      rst_ni,
  input  logic      test_en_i,

  // Write port
  input  logic      we_i,
  input  rf_write_t wcmd_i,

  // Read ports
  input  reg_addr_t raddr_a_i,
  input  reg_addr_t raddr_b_i,
  output reg_data_t rdata_a_o,
  output reg_data_t rdata_b_o
);

  // Storage, word 0 is a constant
  reg_data_t mem [`RF_NUM_WORDS];

  // Global gated clock, only runs on a write cycle
  logic clk_gated;

  // Write data and word select held for the latch phase
  reg_data_t wdata_q;
  logic [`RF_NUM_WORDS-1:1] wsel_q;

  // One-hot write decode and per-word clocks
  logic [`RF_NUM_WORDS-1:1] waddr_onehot;
  logic [`RF_NUM_WORDS-1:1] mem_clocks;

  // Global gate
  rf_clock_gate cg_global_i (
    .clk_i     (clk_int),
    .en_i      (we_i),
    .test_en_i (test_en_i),
    .clk_o     (clk_gated)
  );

  // Sample write data and word select on the gated clock
  // In scan mode the gated clock runs freely, hence the enable
  always_ff @(posedge clk_gated or negedge rst_ni) begin
    if (!rst_ni) begin
      wdata_q <= '0;
      wsel_q  <= '0;
    end else if (we_i) begin
      wdata_q <= wcmd_i.data;
      wsel_q  <= waddr_onehot;
    end
  end

  // Write address decode
  // write stage already dropped x0 so word 0 has no entry
  always_comb begin
    for (int i = 1; i < `RF_NUM_WORDS; i++) begin
      waddr_onehot[i] = we_i && (wcmd_i.addr == reg_addr_t'(i));
    end
  end

  // Per-word gates, fed from the global gated clock
  for (genvar w = 1; w < `RF_NUM_WORDS; w++) begin : gen_word
    rf_clock_gate cg_word_i (
      .clk_i     (clk_gated),
      .en_i      (waddr_onehot[w]),
      .test_en_i (test_en_i),
      .clk_o     (mem_clocks[w])
    );

    // Latch word, open in the high phase after the data sample
    // Word select keeps forced-open gates from copying data into other words
    always_latch begin
      if (mem_clocks[w] && wsel_q[w]) begin
        mem[w] <= wdata_q;
      end
    end
  end

  // Hardwired zero register
  assign mem[0] = '0;

  // Read muxes
  assign rdata_a_o = mem[raddr_a_i];
  assign rdata_b_o = mem[raddr_b_i];

endmodule

`default_nettype wire

//--- src/rf_write_stage.sv
/*
 * Register file write stage
 * Registers writeback strobes and issues them one cycle later
 * Writes to x0 are dropped here
 */

`timescale 1ns/1ps
`default_nettype none

`include "rf_defines.svh"

module rf_write_stage import rf_pkg::*; (
  input  logic      clk_int,
  input  logic      rst_ni,

  // Writeback side
  input  logic      wb_valid_i,
  input  rf_write_t wb_i,

  // Issued write command
  output logic      we_o,
  output rf_write_t wcmd_o
);

  logic      we_q;
  logic      wb_keep;
  rf_write_t wcmd_q;

  // x0 is never written
  assign wb_keep = wb_valid_i && (wb_i.addr != reg_addr_t'(0));

  // Write strobe
  always_ff @(posedge clk_int or negedge rst_ni) begin
    if (!rst_ni) begin
      we_q <= 1'b0;
    end else begin
      we_q <= wb_keep;
    end
  end

  // Command payload, only meaningful with we_q
  always_ff @(posedge clk_int) begin
    if (wb_keep) begin
      wcmd_q <= wb_i;
    end
  end

  assign we_o   = we_q;
  assign wcmd_o = wcmd_q;

endmodule

`default_nettype wire

//--- src/rf_operand_stage.sv
/*
 * Register file operand stage
 * Reads both source registers, forwards the write being issued
 * and returns the operand pair one cycle after the request
 */

`timescale 1ns/1ps
`default_nettype none

`include "rf_defines.svh"

module rf_operand_stage import rf_pkg::*; (
  input  logic         clk_int,
  input  logic         rst_ni,

  // Read request
  input  logic         rd_valid_i,
  input  rf_read_req_t rd_i,

  // Write being issued this cycle
  input  logic         we_i,
  input  rf_write_t    wcmd_i,

  // Latch file read ports
  output reg_addr_t    raddr_a_o,
  output reg_addr_t    raddr_b_o,
  input  reg_data_t    rdata_a_i,
  input  reg_data_t    rdata_b_i,

  // Operand response
  output logic         op_valid_o,
  output rf_operands_t op_o
);

  logic         fwd_a;
  logic         fwd_b;
  rf_operands_t operands_d;
  rf_operands_t operands_q;
  logic         op_valid_q;

  // Addresses go straight to the latch file
  assign raddr_a_o = rd_i.addr_a;
  assign raddr_b_o = rd_i.addr_b;

  // Forward hits
  // x0 never shows up on the write side
  assign fwd_a = we_i && (wcmd_i.addr == rd_i.addr_a);
  assign fwd_b = we_i && (wcmd_i.addr == rd_i.addr_b);

  // Operand select
  always_comb begin
    operands_d.op_a = fwd_a ? wcmd_i.data : rdata_a_i;
    operands_d.op_b = fwd_b ? wcmd_i.data : rdata_b_i;
  end

  // Response strobe
  always_ff @(posedge clk_int or negedge rst_ni) begin
    if (!rst_ni) begin
      op_valid_q <= 1'b0;
    end else begin
      op_valid_q <= rd_valid_i;
    end
  end

  // Operand capture, a new request may land every cycle
  always_ff @(posedge clk_int) begin
    if (rd_valid_i) begin
      operands_q <= operands_d;
    end
  end

  assign op_valid_o = op_valid_q;
  assign op_o       = operands_q;

endmodule

`default_nettype wire

//--- src/rf_subsystem.sv
/*
 * Register file subsystem
 * Write stage, latch file and operand stage of the integer register file
 */

`timescale 1ns/1ps
`default_nettype none

`include "rf_defines.svh"

module rf_subsystem import rf_pkg::*; (
  input  logic         clk_int,
  input  logic         rst_ni,
  input  logic         test_en_i,

  // Writeback strobe
  input  logic         wb_valid_i,
  input  rf_write_t    wb_i,

  // Read strobe
  input  logic         rd_valid_i,
  input  rf_read_req_t rd_i,

  // Operand strobe
  output logic         op_valid_o,
  output rf_operands_t op_o
);

  // Issued write, shared by latch file and forwarding
  logic      we;
  rf_write_t wcmd;

  // Read ports
  reg_addr_t raddr_a;
  reg_addr_t raddr_b;
  reg_data_t rdata_a;
  reg_data_t rdata_b;

  rf_write_stage write_stage_i (
    .clk_int    (clk_int),
    .rst_ni     (rst_ni),
    .wb_valid_i (wb_valid_i),
    .wb_i       (wb_i),
    .we_o       (we),
    .wcmd_o     (wcmd)
  );

  rf_latch_file latch_file_i (
    .clk_int   (clk_int),
    .rst_ni    (rst_ni),
    .test_en_i (test_en_i),
    .we_i      (we),
    .wcmd_i    (wcmd),
    .raddr_a_i (raddr_a),
    .raddr_b_i (raddr_b),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b)
  );

  rf_operand_stage operand_stage_i (
    .clk_int    (clk_int),
    .rst_ni     (rst_ni),
    .rd_valid_i (rd_valid_i),
    .rd_i       (rd_i),
    .we_i       (we),
    .wcmd_i     (wcmd),
    .raddr_a_o  (raddr_a),
    .raddr_b_o  (raddr_b),
    .rdata_a_i  (rdata_a),
    .rdata_b_i  (rdata_b),
    .op_valid_o (op_valid_o),
    .op_o       (op_o)
  );

endmodule

`default_nettype wire

//--- verification/rf_subsystem_checker.sv
/*
 * Register file subsystem checker
 * Shadow register model plus strobe latency, operand and x0 assertions
 */

`timescale 1ns/1ps
`default_nettype none

`include "rf_defines.svh"

module rf_subsystem_checker import rf_pkg::*; (
  input logic         clk_int,
  input logic         rst_ni,
  input logic         wb_valid_i,
  input rf_write_t    wb_i,
  input logic         rd_valid_i,
  input rf_read_req_t rd_i,
  input logic         op_valid_i,
  input rf_operands_t op_i
);

  // Set on any assertion failure
  logic fail_flag = 1'b0;

  // Shadow registers, x0 fixed at zero
  reg_data_t    shadow [`RF_NUM_WORDS];
  rf_operands_t exp_q;
  logic         rd_valid_q;

  // A write becomes visible from the cycle after its strobe
  always_ff @(posedge clk_int or negedge rst_ni) begin
    if (!rst_ni) begin
      shadow[0] <= '0;
    end else if (wb_valid_i && (wb_i.addr != reg_addr_t'(0))) begin
      shadow[wb_i.addr] <= wb_i.data;
    end
  end

  // Expected operands, read from the shadow before this cycle's write
  always_ff @(posedge clk_int) begin
    if (rd_valid_i) begin
      exp_q.op_a <= shadow[rd_i.addr_a];
      exp_q.op_b <= shadow[rd_i.addr_b];
    end
  end

  // Delayed read strobe
  always_ff @(posedge clk_int or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_valid_q <= 1'b0;
    end else begin
      rd_valid_q <= rd_valid_i;
    end
  end

  // Strobe is never unknown out of reset
  strobe_known_a: assert property (@(posedge clk_int) disable iff (!rst_ni)
    !$isunknown(op_valid_i))
    else begin
      $error("op_valid_o is unknown after reset");
      fail_flag = 1'b1;
    end

  // Exactly one cycle of latency
  latency_a: assert property (@(posedge clk_int) disable iff (!rst_ni)
    op_valid_i == rd_valid_q)
    else begin
      $error("ERR %0t op_valid_o got %b expected %b", $time,
             $sampled(op_valid_i), $sampled(rd_valid_q));
      fail_flag = 1'b1;
    end

  // Operands against the model
  op_a_match_a: assert property (@(posedge clk_int) disable iff (!rst_ni)
    op_valid_i |-> (op_i.op_a == exp_q.op_a))
    else begin
      $error("ERR %0t op_o.op_a got %h expected %h", $time,
             $sampled(op_i.op_a), $sampled(exp_q.op_a));
      fail_flag = 1'b1;
    end

  op_b_match_a: assert property (@(posedge clk_int) disable iff (!rst_ni)
    op_valid_i |-> (op_i.op_b == exp_q.op_b))
    else begin
      $error("ERR %0t op_o.op_b got %h expected %h", $time,
             $sampled(op_i.op_b), $sampled(exp_q.op_b));
      fail_flag = 1'b1;
    end

  // x0 reads as zero on both ports
  x0_a_a: assert property (@(posedge clk_int) disable iff (!rst_ni)
    (rd_valid_i && (rd_i.addr_a == reg_addr_t'(0))) |=> (op_i.op_a == '0))
    else begin
      $error("ERR %0t op_o.op_a got %h expected 0 for x0", $time,
             $sampled(op_i.op_a));
      fail_flag = 1'b1;
    end

  x0_b_a: assert property (@(posedge clk_int) disable iff (!rst_ni)
    (rd_valid_i && (rd_i.addr_b == reg_addr_t'(0))) |=> (op_i.op_b == '0))
    else begin
      $error("ERR %0t op_o.op_b got %h expected 0 for x0", $time,
             $sampled(op_i.op_b));
      fail_flag = 1'b1;
    end

endmodule

bind rf_subsystem rf_subsystem_checker checker_i (
  .clk_int    (clk_int),
  .rst_ni     (rst_ni),
  .wb_valid_i (wb_valid_i),
  .wb_i       (wb_i),
  .rd_valid_i (rd_valid_i),
  .rd_i       (rd_i),
  .op_valid_i (op_valid_o),
  .op_i       (op_o)
);

`default_nettype wire

//--- verification/rf_subsystem_tb.sv
/*
 * Register file subsystem testbench
 * LFSR writes and reads, directed forwarding and x0 cases, scan mode traffic
 */

`timescale 1ns/1ps
`default_nettype none

`include "rf_defines.svh"

module rf_subsystem_tb import rf_pkg::*; ();

  localparam int          CLK_PERIOD    = 20;
  localparam int          RESET_CYCLES  = 3;
  localparam int          IDLE_CYCLES   = 4;
  localparam int          FILL_CYCLES   = `RF_NUM_WORDS + 2;
  localparam int          RANDOM_CYCLES = 200;
  localparam int          FWD_REGS      = 4;
  localparam int          FWD_CYCLES    = FWD_REGS * 3 + 3;
  localparam int          SCAN_CYCLES   = 150;
  localparam int          SWEEP_CYCLES  = `RF_NUM_WORDS / 2 + 1;
  localparam int          END_CYCLES    = 2;
  localparam int          TIMEOUT_CYCLES = RESET_CYCLES + IDLE_CYCLES + FILL_CYCLES +
                                           RANDOM_CYCLES + FWD_CYCLES + SCAN_CYCLES +
                                           2 * SWEEP_CYCLES + END_CYCLES + 100;
  localparam logic [31:0] LFSR_SEED     = 32'h6aa4_be12;

  logic         clk_int;
  logic         rst_ni;
  logic         test_en;
  logic         wb_valid;
  rf_write_t    wb;
  logic         rd_valid;
  rf_read_req_t rd;
  logic         op_valid;
  rf_operands_t op;

  logic [31:0]  lfsr_state;
  int unsigned  cycle_cnt = 0;

  rf_subsystem rf_subsystem_i (
    .clk_int    (clk_int),
    .rst_ni     (rst_ni),
    .test_en_i  (test_en),
    .wb_valid_i (wb_valid),
    .wb_i       (wb),
    .rd_valid_i (rd_valid),
    .rd_i       (rd),
    .op_valid_o (op_valid),
    .op_o       (op)
  );

  // Free running clock
  initial begin
    clk_int = 1'b0;
    forever #(CLK_PERIOD / 2) clk_int = ~clk_int;
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  // One LFSR step per bit taken
  task automatic take_bits(input int count, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < count; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      bits = {bits[30:0], lfsr_state[0]};
    end
  endtask

  // Inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk_int);
    #1;
  endtask

  task automatic drive_cycle(input logic wv, input reg_addr_t wa, input reg_data_t wd,
                             input logic rv, input reg_addr_t ra, input reg_addr_t rb);
    wb_valid  = wv;
    wb.addr   = wa;
    wb.data   = wd;
    rd_valid  = rv;
    rd.addr_a = ra;
    rd.addr_b = rb;
    next_cycle();
  endtask

  task automatic drive_idle();
    drive_cycle(1'b0, '0, '0, 1'b0, '0, '0);
  endtask

  // Every word once, x0 included, so later reads are defined
  task automatic fill_registers();
    logic [31:0] bits;
    for (int i = 0; i < `RF_NUM_WORDS; i++) begin
      take_bits(32, bits);
      drive_cycle(1'b1, reg_addr_t'(i), bits, 1'b0, '0, '0);
    end
    drive_idle();
    drive_idle();
  endtask

  // Mixed strobes, reads in about three cycles of four
  task automatic random_traffic(input int cycles);
    logic [31:0] bits;
    logic        wv;
    logic        rv;
    reg_addr_t   wa;
    reg_addr_t   ra;
    reg_addr_t   rb;
    reg_data_t   wd;
    for (int i = 0; i < cycles; i++) begin
      take_bits(1, bits);
      wv = bits[0];
      take_bits(`RF_ADDR_WIDTH, bits);
      wa = bits[`RF_ADDR_WIDTH-1:0];
      take_bits(32, bits);
      wd = bits;
      take_bits(2, bits);
      rv = |bits[1:0];
      take_bits(`RF_ADDR_WIDTH, bits);
      ra = bits[`RF_ADDR_WIDTH-1:0];
      take_bits(`RF_ADDR_WIDTH, bits);
      rb = bits[`RF_ADDR_WIDTH-1:0];
      drive_cycle(wv, wa, wd, rv, ra, rb);
    end
  endtask

  // Same cycle read sees old data, next cycle is forwarded, then the latch
  task automatic forwarding_sequence();
    logic [31:0] bits;
    reg_addr_t   r;
    for (int k = 0; k < FWD_REGS; k++) begin
      take_bits(`RF_ADDR_WIDTH, bits);
      r = bits[`RF_ADDR_WIDTH-1:0];
      if (r == '0) begin
        r = reg_addr_t'(1);
      end
      take_bits(32, bits);
      drive_cycle(1'b1, r, bits, 1'b1, r, r);
      drive_cycle(1'b0, '0, '0, 1'b1, r, r);
      drive_cycle(1'b0, '0, '0, 1'b1, r, r);
    end
    // Write to x0 followed by x0 reads
    drive_cycle(1'b1, '0, 32'hdead_beef, 1'b1, '0, '0);
    drive_cycle(1'b0, '0, '0, 1'b1, '0, '0);
    drive_idle();
  endtask

  // Read back all words in pairs
  task automatic read_sweep();
    for (int i = 0; i < `RF_NUM_WORDS / 2; i++) begin
      drive_cycle(1'b0, '0, '0, 1'b1, reg_addr_t'(2 * i), reg_addr_t'(2 * i + 1));
    end
    drive_idle();
  endtask

  // Run limit
  always @(posedge clk_int) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("STATUS: FAIL");
      $fatal(1, "Timeout");
    end
  end

  // Stop at the first checker failure
  initial begin
    wait (rf_subsystem_i.checker_i.fail_flag === 1'b1);
    $display("STATUS: FAIL");
    $fatal(1, "Checker assertion failed");
  end

  initial begin
    lfsr_state = LFSR_SEED;
    test_en    = 1'b0;
    wb_valid   = 1'b0;
    wb         = '0;
    rd_valid   = 1'b0;
    rd         = '0;
    rst_ni     = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_int);
    #1;
    rst_ni = 1'b1;

    // Quiet cycles, strobe must stay low
    repeat (IDLE_CYCLES) drive_idle();
    fill_registers();
    random_traffic(RANDOM_CYCLES);
    forwarding_sequence();

    // Scan mode with all gates forced open
    test_en = 1'b1;
    random_traffic(SCAN_CYCLES);
    read_sweep();
    test_en = 1'b0;
    read_sweep();
    repeat (END_CYCLES) drive_idle();

    if (rf_subsystem_i.checker_i.fail_flag) begin
      $display("STATUS: FAIL");
      $fatal(1, "Checker assertion failed");
    end else begin
      $display("STATUS: PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- list.f
+incdir+src
src/rf_pkg.sv
src/rf_clock_gate.sv
src/rf_latch_file.sv
src/rf_write_stage.sv
src/rf_operand_stage.sv
src/rf_subsystem.sv
verification/rf_subsystem_checker.sv
verification/rf_subsystem_tb.sv
